/* logic/adc_rx_cfg.svh */
/*
  build-time configuration of the ADC receive front end
  ADC_NUM_CHANNELS may be set from 1 to 8, limited by the 8-bit enable,
  swap and status fields of the register map
  ADC_WORD_W must stay even since each word carries two sample halves
*/
`ifndef ADC_RX_CFG_SVH
`define ADC_RX_CFG_SVH

// number of ADC channels and size of the gearbox generate loop
`define ADC_NUM_CHANNELS 2

// one channel's Q or I word, two 16-bit samples side by side
`define ADC_WORD_W 32

// APB byte address width
`define APB_ADDR_W 8

`endif

/* logic/adc_rx_pkg.sv */
/*
  register map and control register layout of the ADC receive front end
  register addresses are byte addresses on a 32-bit APB data bus
  fields are 8 bits wide whatever the channel count, unused bits read back as written
*/
`include "adc_rx_cfg.svh"

package adc_rx_pkg;

  // register byte addresses, anything else is unmapped and errors
  typedef enum logic [`APB_ADDR_W-1:0] {
    ADDR_CTRL   = 8'h00,
    ADDR_STATUS = 8'h04
  } reg_addr_e;

  // CTRL register, swap in bits 15:8 and per-channel enable in bits 7:0
  // a set swap bit puts I in the upper half of the output word
  typedef struct packed {
    logic [7:0] swap;
    logic [7:0] enable;
  } ctrl_reg_t;

endpackage

/* logic/adc_lane_if.sv */
/*
  one channel's clk1x-domain lane from ingress to its gearbox
  data and valid are registered copies of the raw ADC bus
  enable follows the CTRL register one clk1x cycle late
*/
`timescale 1ns/1ps
`include "adc_rx_cfg.svh"

interface adc_lane_if;

  // two samples per word, sample1 in the upper half
  logic [`ADC_WORD_W-1:0] q_data;
  logic [`ADC_WORD_W-1:0] i_data;
  logic                   valid;
  // a low enable makes the gearbox drop the word
  logic                   enable;

  // ingress side drives everything
  modport src (output q_data, output i_data, output valid, output enable);

  // gearbox side only samples
  modport snk (input q_data, input i_data, input valid, input enable);

endinterface

/* logic/adc_rx_ingress.sv */
/*
  APB register file and raw ADC capture for all channels
  APB has no wait states, pready is always high and an unmapped access
  raises pslverr for that access only
  swap bits are double-synced into clk2x, a swap change therefore lands a
  few clk2x cycles late and may split one word across both orders
*/
`timescale 1ns/1ps
`include "adc_rx_cfg.svh"

module adc_rx_ingress
  import adc_rx_pkg::*;
(
  input  logic                                      clk1x,
  input  logic                                      reset_n_1x,
  input  logic                                      clk2x,
  input  logic                                      psel,
  input  logic                                      penable,
  input  logic                                      pwrite,
  input  logic [`APB_ADDR_W-1:0]                    paddr,
  input  logic [31:0]                               pwdata,
  output logic [31:0]                               prdata,
  output logic                                      pready,
  output logic                                      pslverr,
  input  logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0]  adc_q_in,
  input  logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0]  adc_i_in,
  input  logic [`ADC_NUM_CHANNELS-1:0]              adc_valid_in,
  output logic [`ADC_NUM_CHANNELS-1:0]              swap_iq_2x,
  adc_lane_if.src                                   lanes [`ADC_NUM_CHANNELS]
);

  localparam int NCH = `ADC_NUM_CHANNELS;
  localparam int WW  = `ADC_WORD_W;

  ctrl_reg_t           ctrl;
  logic [7:0]          status;
  logic [7:0]          status_set;
  logic [31:0]         rd_word;
  logic                addr_hit;
  logic                access;
  logic                wr_ctrl;
  logic                wr_status;
  logic [NCH*WW-1:0]   cap_q;
  logic [NCH*WW-1:0]   cap_i;
  logic [NCH-1:0]      cap_valid;
  logic [NCH-1:0]      lane_en;
  // the 2x domain has no reset, these start at zero and follow CTRL
  logic [NCH-1:0]      swap_meta_2x = '0;
  logic [NCH-1:0]      swap_sync_2x = '0;

  // every access completes in its access phase
  assign pready    = 1'b1;
  assign access    = psel && penable;
  assign wr_ctrl   = access && pwrite && (paddr == ADDR_CTRL);
  assign wr_status = access && pwrite && (paddr == ADDR_STATUS);

  // read mux, unmapped addresses read zero and flag an error
  always_comb begin
    addr_hit = 1'b1;
    rd_word  = '0;
    case (paddr)
      ADDR_CTRL:   rd_word = {16'b0, ctrl};
      ADDR_STATUS: rd_word = {24'b0, status};
      default:     addr_hit = 1'b0;
    endcase
  end

  assign prdata  = (access && !pwrite) ? rd_word : 32'b0;
  assign pslverr = access && !addr_hit;

  // a word captured while its lane is disabled gets dropped, so remember it
  always_comb begin
    status_set          = '0;
    status_set[NCH-1:0] = cap_valid & ~lane_en;
  end

  always_ff @(posedge clk1x or negedge reset_n_1x) begin
    if (!reset_n_1x) begin
      ctrl    <= '0;
      status  <= '0;
      lane_en <= '0;
    end else begin
      if (wr_ctrl) begin
        ctrl <= ctrl_reg_t'(pwdata[15:0]);
      end
      // set wins over a write-1-to-clear in the same cycle
      status  <= (wr_status ? (status & ~pwdata[7:0]) : status) | status_set;
      lane_en <= ctrl.enable[NCH-1:0];
    end
  end

  // capture the raw buses once, only the valid bits need a reset
  always_ff @(posedge clk1x) begin
    cap_q <= adc_q_in;
    cap_i <= adc_i_in;
  end

  always_ff @(posedge clk1x or negedge reset_n_1x) begin
    if (!reset_n_1x) begin
      cap_valid <= '0;
    end else begin
      cap_valid <= adc_valid_in;
    end
  end

  // two-flop synchronizer carrying the swap bits into clk2x
  always_ff @(posedge clk2x) begin
    swap_meta_2x <= ctrl.swap[NCH-1:0];
    swap_sync_2x <= swap_meta_2x;
  end

  assign swap_iq_2x = swap_sync_2x;

  for (genvar g = 0; g < NCH; g++) begin : g_lane
    assign lanes[g].q_data = cap_q[g*WW +: WW];
    assign lanes[g].i_data = cap_i[g*WW +: WW];
    assign lanes[g].valid  = cap_valid[g];
    assign lanes[g].enable = lane_en[g];
  end

  // a transfer reaches its access phase only straight from its setup phase
  a_access_after_setup: assert property (@(posedge clk1x) disable iff (!reset_n_1x)
    (psel && penable) |-> $past(psel && !penable));

  // the enable strobe means nothing without a select
  a_penable_with_psel: assert property (@(posedge clk1x) disable iff (!reset_n_1x)
    penable |-> psel);

endmodule

/* logic/adc_gearbox_2x1.sv */
/*
  2 samples per clk1x to 1 sample per clk2x gearbox for one channel
  clk2x must be exactly twice clk1x with nominally aligned rising edges
  the 2x side has no reset and is flushed by the 1x-reset lane signals
  output is sample0 then sample1 of each word, Q high and I low unless swapped
*/
`timescale 1ns/1ps
`include "adc_rx_cfg.svh"

module adc_gearbox_2x1 (
  input  logic                   clk1x,
  input  logic                   reset_n_1x,
  input  logic                   clk2x,
  adc_lane_if.snk                lane,
  input  logic                   swap_iq_2x,
  output logic [`ADC_WORD_W-1:0] adc_out_2x,
  output logic                   valid_out_2x
);

  localparam int WW = `ADC_WORD_W;
  localparam int HW = `ADC_WORD_W / 2;

  logic          toggle_1x;
  // falling-edge resample of the lane, half a clk2x period either side
  logic          toggle_fall   = 1'b0;
  logic [WW-1:0] q_fall        = '0;
  logic [WW-1:0] i_fall        = '0;
  logic          valid_fall    = 1'b0;
  logic          enable_fall   = 1'b0;
  // rising-edge 2x stage
  logic          toggle_2x     = 1'b0;
  logic          toggle_dly_2x = 1'b0;
  logic [WW-1:0] q_2x          = '0;
  logic [WW-1:0] i_2x          = '0;
  logic          valid_2x      = 1'b0;
  logic          valid_dly_2x  = 1'b0;
  logic [WW-1:0] data_out_2x   = '0;
  logic          run_odd_2x    = 1'b0;
  logic          first_half;
  logic [HW-1:0] q_half;
  logic [HW-1:0] i_half;

  // clk1x divided by two marks which clk2x phase of the word we are in
  always_ff @(posedge clk1x or negedge reset_n_1x) begin
    if (!reset_n_1x) begin
      toggle_1x <= 1'b0;
    end else begin
      toggle_1x <= !toggle_1x;
    end
  end

  always_ff @(negedge clk2x) begin
    toggle_fall <= toggle_1x;
    q_fall      <= lane.q_data;
    i_fall      <= lane.i_data;
    valid_fall  <= lane.valid;
    enable_fall <= lane.enable;
  end

  // the toggle differs from its delayed copy in the first clk2x cycle of a word
  assign first_half = (toggle_2x != toggle_dly_2x);
  assign q_half     = first_half ? q_2x[HW-1:0] : q_2x[WW-1:HW];
  assign i_half     = first_half ? i_2x[HW-1:0] : i_2x[WW-1:HW];

  always_ff @(posedge clk2x) begin
    toggle_2x     <= toggle_fall;
    toggle_dly_2x <= toggle_2x;
    q_2x          <= q_fall;
    i_2x          <= i_fall;
    valid_2x      <= valid_fall && enable_fall;
    // valid takes one more stage to line up with the packed data
    valid_dly_2x  <= valid_2x;
    if (!valid_2x) begin
      data_out_2x <= '0;
    end else if (swap_iq_2x) begin
      data_out_2x <= {i_half, q_half};
    end else begin
      data_out_2x <= {q_half, i_half};
    end
  end

  assign adc_out_2x   = data_out_2x;
  assign valid_out_2x = valid_dly_2x;

  // parity of the current valid run, checked when the run ends
  always_ff @(posedge clk2x) begin
    run_odd_2x <= valid_out_2x ? !run_odd_2x : 1'b0;
  end

  // every lane word must leave as a full sample0 and sample1 pair
  a_valid_even_runs: assert property (@(posedge clk2x)
    $fell(valid_out_2x) |-> !run_odd_2x);

endmodule

/* logic/adc_lane_combine.sv */
/*
  one clk2x register stage onto the wide output bus plus a burst-start flag
  frame_start marks the first valid cycle of any channel after an idle cycle,
  so channels that start in the same cycle share one pulse
  no reset, the stage is flushed by the gearbox outputs
*/
`timescale 1ns/1ps
`include "adc_rx_cfg.svh"

module adc_lane_combine (
  input  logic                                      clk2x,
  input  logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0]  lane_data,
  input  logic [`ADC_NUM_CHANNELS-1:0]              lane_valid,
  output logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0]  adc_out,
  output logic [`ADC_NUM_CHANNELS-1:0]              adc_valid_out,
  output logic                                      frame_start
);

  logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0] out_q   = '0;
  logic [`ADC_NUM_CHANNELS-1:0]             valid_q = '0;
  logic                                     start_q = 1'b0;
  logic                                     any_valid_now;
  logic                                     any_valid_prev;

  assign any_valid_now  = |lane_valid;
  // the registered valids are exactly last cycle's channel activity
  assign any_valid_prev = |valid_q;

  always_ff @(posedge clk2x) begin
    out_q   <= lane_data;
    valid_q <= lane_valid;
    start_q <= any_valid_now && !any_valid_prev;
  end

  assign adc_out       = out_q;
  assign adc_valid_out = valid_q;
  assign frame_start   = start_q;

  // an idle gearbox must hand over zero data for the wide bus
  for (genvar g = 0; g < `ADC_NUM_CHANNELS; g++) begin : g_idle_zero
    a_idle_lane_zero: assert property (@(posedge clk2x)
      !lane_valid[g] |-> (lane_data[g*`ADC_WORD_W +: `ADC_WORD_W] == '0));
  end

endmodule

/* logic/adc_rx_frontend.sv */
/*
  top level of the multi-channel ADC receive front end
  clk2x must be exactly twice clk1x with nominally aligned rising edges
  output words are Q high and I low per channel unless that channel's swap
  bit is set, there is no back-pressure on the output stream
*/
`timescale 1ns/1ps
`include "adc_rx_cfg.svh"

module adc_rx_frontend (
  input  logic                                      clk1x,
  input  logic                                      clk2x,
  input  logic                                      reset_n_1x,
  input  logic                                      psel,
  input  logic                                      penable,
  input  logic                                      pwrite,
  input  logic [`APB_ADDR_W-1:0]                    paddr,
  input  logic [31:0]                               pwdata,
  output logic [31:0]                               prdata,
  output logic                                      pready,
  output logic                                      pslverr,
  input  logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0]  adc_q_in,
  input  logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0]  adc_i_in,
  input  logic [`ADC_NUM_CHANNELS-1:0]              adc_valid_in,
  output logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0]  adc_out,
  output logic [`ADC_NUM_CHANNELS-1:0]              adc_valid_out,
  output logic                                      frame_start
);

  logic [`ADC_NUM_CHANNELS-1:0]             swap_iq_2x;
  logic [`ADC_NUM_CHANNELS*`ADC_WORD_W-1:0] lane_data;
  logic [`ADC_NUM_CHANNELS-1:0]             lane_valid;

  // one lane per channel between ingress and its gearbox
  adc_lane_if lanes [`ADC_NUM_CHANNELS] ();

  adc_rx_ingress u_ingress (
    .clk1x        (clk1x),
    .reset_n_1x   (reset_n_1x),
    .clk2x        (clk2x),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .adc_q_in     (adc_q_in),
    .adc_i_in     (adc_i_in),
    .adc_valid_in (adc_valid_in),
    .swap_iq_2x   (swap_iq_2x),
    .lanes        (lanes)
  );

  for (genvar g = 0; g < `ADC_NUM_CHANNELS; g++) begin : g_gearbox
    adc_gearbox_2x1 u_gearbox (
      .clk1x        (clk1x),
      .reset_n_1x   (reset_n_1x),
      .clk2x        (clk2x),
      .lane         (lanes[g]),
      .swap_iq_2x   (swap_iq_2x[g]),
      .adc_out_2x   (lane_data[g*`ADC_WORD_W +: `ADC_WORD_W]),
      .valid_out_2x (lane_valid[g])
    );
  end

  adc_lane_combine u_combine (
    .clk2x         (clk2x),
    .lane_data     (lane_data),
    .lane_valid    (lane_valid),
    .adc_out       (adc_out),
    .adc_valid_out (adc_valid_out),
    .frame_start   (frame_start)
  );

endmodule

/* testbench/adc_rx_frontend_tb.sv */
/*
  testbench of the ADC receive front end, APB register checks first and then
  a table of bursts applied in a loop, each table row counted as one test
  expected STATUS values in the table assume the default of two channels
  outputs are checked for order and count through per-channel queues,
  the gearbox latency itself is not checked
*/
`timescale 1ns/1ps
`include "adc_rx_cfg.svh"

module adc_rx_frontend_tb
  import adc_rx_pkg::*;
();

  localparam int NCH         = `ADC_NUM_CHANNELS;
  localparam int WW          = `ADC_WORD_W;
  localparam int HW          = WW / 2;
  localparam int NROWS       = 5;
  localparam int APB_LIMIT   = 8;
  localparam int DRAIN_LIMIT = 200;

  // one burst per row, STATUS is read back once the burst has drained
  typedef struct packed {
    ctrl_reg_t  ctrl;
    logic [7:0] burst;
    logic [7:0] gap;
    logic [7:0] status;
  } row_t;

  logic                   clk1x;
  logic                   clk2x;
  logic                   reset_n_1x;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  logic [NCH*WW-1:0]      adc_q_in;
  logic [NCH*WW-1:0]      adc_i_in;
  logic [NCH-1:0]         adc_valid_in;
  logic [NCH*WW-1:0]      adc_out;
  logic [NCH-1:0]         adc_valid_out;
  logic                   frame_start;

  row_t        rows [NROWS];
  // each entry carries a burst-start mark above the data word
  logic [WW:0] exp_q [NCH][$];
  logic [WW:0] popped;
  logic        any_first;
  logic        monitor_on;
  int          seed = 32'hd89c8274;
  int          errors;
  int          err_mark;
  int          starts;
  int          tests_passed;
  int          tests_failed;

  adc_rx_frontend dut (
    .clk1x         (clk1x),
    .clk2x         (clk2x),
    .reset_n_1x    (reset_n_1x),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .adc_q_in      (adc_q_in),
    .adc_i_in      (adc_i_in),
    .adc_valid_in  (adc_valid_in),
    .adc_out       (adc_out),
    .adc_valid_out (adc_valid_out),
    .frame_start   (frame_start)
  );

  // clk2x starts high so both clocks rise together at 10 ns, 30 ns and on
  initial begin
    clk1x = 1'b0;
    forever #10 clk1x = ~clk1x;
  end

  initial begin
    clk2x = 1'b1;
    forever #5 clk2x = ~clk2x;
  end

  // Q high and I low unless the channel is swapped
  function automatic logic [WW-1:0] pack_iq(input logic [HW-1:0] q_half,
                                            input logic [HW-1:0] i_half,
                                            input logic swap);
    return swap ? {i_half, q_half} : {q_half, i_half};
  endfunction

  function automatic logic queues_busy();
    logic busy;
    busy = 1'b0;
    for (int c = 0; c < NCH; c++) begin
      busy = busy | (exp_q[c].size() != 0);
    end
    return busy;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      tests_passed++;
      $display("test %s passed at %0t", name, $time);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - err_mark);
    end
  endtask

  // setup phase, then access phase held until pready, data sampled mid-cycle
  task automatic apb_transfer(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int n;
    n = 0;
    @(posedge clk1x);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk1x);
    penable <= 1'b1;
    @(negedge clk1x);
    while (!pready && n < APB_LIMIT) begin
      @(negedge clk1x);
      n++;
    end
    if (!pready) begin
      $display("timeout: pready stayed low for %0d clk1x cycles at %0t", APB_LIMIT, $time);
      $display("TB FAILED");
      $finish;
    end else begin
      rdata = prdata;
      err   = pslverr;
      @(posedge clk1x);
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  // one random word on every channel, valid everywhere, enabled ones expect two outputs
  task automatic drive_word(input ctrl_reg_t ctrl, input logic first);
    logic [WW-1:0] q;
    logic [WW-1:0] i;
    @(posedge clk1x);
    for (int c = 0; c < NCH; c++) begin
      q = $random(seed);
      i = $random(seed);
      adc_q_in[c*WW +: WW] <= q;
      adc_i_in[c*WW +: WW] <= i;
      if (ctrl.enable[c]) begin
        exp_q[c].push_back({first, pack_iq(q[HW-1:0], i[HW-1:0], ctrl.swap[c])});
        exp_q[c].push_back({1'b0, pack_iq(q[WW-1:HW], i[WW-1:HW], ctrl.swap[c])});
      end
    end
    adc_valid_in <= '1;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (queues_busy() && n < DRAIN_LIMIT) begin
      @(posedge clk2x);
      n++;
    end
    if (queues_busy()) begin
      $display("timeout: expected outputs still pending after %0d clk2x cycles at %0t",
               DRAIN_LIMIT, $time);
      $display("TB FAILED");
      $finish;
    end
  endtask

  task automatic run_row(input int r);
    row_t        row;
    logic [31:0] rdata;
    logic        err;
    int          starts_mark;
    row         = rows[r];
    err_mark    = errors;
    starts_mark = starts;
    apb_transfer(1'b1, ADDR_CTRL, {16'b0, row.ctrl}, rdata, err);
    apb_transfer(1'b0, ADDR_CTRL, 32'd0, rdata, err);
    check_value("CTRL readback", rdata, {16'b0, row.ctrl});
    for (int w = 0; w < int'(row.burst); w++) begin
      drive_word(row.ctrl, w == 0);
    end
    for (int g = 0; g < int'(row.gap); g++) begin
      @(posedge clk1x);
      adc_valid_in <= '0;
    end
    wait_drain();
    // a burst on any enabled channel gives exactly one start pulse
    check_value("burst start count", starts - starts_mark,
                (|row.ctrl.enable[NCH-1:0]) ? 32'd1 : 32'd0);
    apb_transfer(1'b0, ADDR_STATUS, 32'd0, rdata, err);
    check_value("STATUS", rdata, {24'b0, row.status});
    if (row.status != 8'h00) begin
      apb_transfer(1'b1, ADDR_STATUS, {24'b0, row.status}, rdata, err);
      apb_transfer(1'b0, ADDR_STATUS, 32'd0, rdata, err);
      check_value("STATUS after clear", rdata, 32'd0);
    end
    end_test($sformatf("row %0d", r));
  endtask

  // output monitor, sampled on the falling clk2x edge while outputs are stable
  initial begin : monitor
    forever begin
      @(negedge clk2x);
      if (monitor_on) begin
        any_first = 1'b0;
        for (int c = 0; c < NCH; c++) begin
          if (adc_valid_out[c]) begin
            assert (exp_q[c].size() > 0) else begin
              $display("unexpected valid output on channel %0d at %0t", c, $time);
              errors++;
            end
            if (exp_q[c].size() > 0) begin
              popped    = exp_q[c].pop_front();
              any_first = any_first | popped[WW];
              assert (adc_out[c*WW +: WW] === popped[WW-1:0]) else begin
                $display("mismatch at %0t: channel %0d output %h, expected %h",
                         $time, c, adc_out[c*WW +: WW], popped[WW-1:0]);
                errors++;
              end
            end
          end else begin
            assert (adc_out[c*WW +: WW] === '0) else begin
              $display("mismatch at %0t: channel %0d idle data %h, expected zero",
                       $time, c, adc_out[c*WW +: WW]);
              errors++;
            end
          end
        end
        assert (frame_start === any_first) else begin
          $display("mismatch at %0t: frame_start %b, expected %b",
                   $time, frame_start, any_first);
          errors++;
        end
        if (frame_start === 1'b1) begin
          starts++;
        end
      end
    end
  end

  initial begin : main
    logic [31:0] rdata;
    logic        err;
    reset_n_1x   = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    adc_q_in     = '0;
    adc_i_in     = '0;
    adc_valid_in = '0;
    monitor_on   = 1'b0;
    errors       = 0;
    starts       = 0;
    tests_passed = 0;
    tests_failed = 0;
    // columns: ctrl {swap, enable}, burst words, gap cycles, expected STATUS
    rows[0] = '{'{8'h00, 8'h03}, 8'd4, 8'd2, 8'h00};
    rows[1] = '{'{8'h02, 8'h03}, 8'd3, 8'd3, 8'h00};
    rows[2] = '{'{8'h00, 8'h01}, 8'd3, 8'd2, 8'h02};
    rows[3] = '{'{8'h01, 8'h02}, 8'd5, 8'd4, 8'h01};
    rows[4] = '{'{8'h03, 8'h03}, 8'd1, 8'd2, 8'h00};

    repeat (3) @(posedge clk1x);
    reset_n_1x <= 1'b1;
    // give the cleared 1x signals time to flush the 2x side
    repeat (4) @(posedge clk1x);
    monitor_on = 1'b1;

    // register file straight out of reset, readback and an unmapped address
    err_mark = errors;
    @(negedge clk1x);
    check_value("idle pready", {31'b0, pready}, 32'd1);
    check_value("idle pslverr", {31'b0, pslverr}, 32'd0);
    check_value("idle prdata", prdata, 32'd0);
    apb_transfer(1'b0, ADDR_CTRL, 32'd0, rdata, err);
    check_value("CTRL after reset", rdata, 32'd0);
    apb_transfer(1'b0, ADDR_STATUS, 32'd0, rdata, err);
    check_value("STATUS after reset", rdata, 32'd0);
    apb_transfer(1'b1, ADDR_CTRL, 32'h0000_a5c3, rdata, err);
    apb_transfer(1'b0, ADDR_CTRL, 32'd0, rdata, err);
    check_value("CTRL readback", rdata, 32'h0000_a5c3);
    check_value("CTRL pslverr", {31'b0, err}, 32'd0);
    apb_transfer(1'b0, 8'h08, 32'd0, rdata, err);
    check_value("unmapped read data", rdata, 32'd0);
    check_value("unmapped pslverr", {31'b0, err}, 32'd1);
    end_test("registers");

    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* adc_rx_frontend.f */
+incdir+logic
logic/adc_rx_pkg.sv
logic/adc_lane_if.sv
logic/adc_rx_ingress.sv
logic/adc_gearbox_2x1.sv
logic/adc_lane_combine.sv
logic/adc_rx_frontend.sv
testbench/adc_rx_frontend_tb.sv

/* Makefile */
TB_TOP = adc_rx_frontend_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f adc_rx_frontend.f --top-module adc_rx_frontend

sim:
	verilator --binary --timing --assert -f adc_rx_frontend.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
